// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data word carried on the internal bus and to memory
`define CPU_DATA_W 8

// Memory address width, 256 locations
`define CPU_ADDR_W 8

// Upper field of the instruction byte
`define CPU_OP_W 4

// Immediate nibble for LLS and LMS
`define CPU_NIB_W 4

// Z, N, C and V
`define CPU_FLAG_W 4

`endif

// File: common/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] data_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_NIB_W-1:0]  nibble_t;

	// Upper four bits of the instruction byte
	typedef enum logic [`CPU_OP_W-1:0] {
		NOP = 4'd0,
		JMP = 4'd1,
		RDM = 4'd2,
		WRM = 4'd3,
		CPR = 4'd4,
		ADD = 4'd5,
		SUB = 4'd6,
		LLS = 4'd7,
		LMS = 4'd8,
		CFR = 4'd9
	} opcode_e;

	// Register codes in bits 3:2 and 1:0
	typedef enum logic [1:0] {
		AR = 2'd0,
		DR = 2'd1,
		GR = 2'd2,
		PR = 2'd3
	} reg_sel_e;

	typedef enum logic [1:0] {
		ST_RST    = 2'd0,
		ST_FETCH  = 2'd1,
		ST_DECODE = 2'd2,
		ST_EXEC   = 2'd3
	} state_e;

	// Nine sources, so one more bit than a 3-bit field can hold
	typedef enum logic [3:0] {
		SRC_NONE, SRC_AR, SRC_DR, SRC_GR, SRC_PR,
		SRC_IR_NIB, SRC_ALU, SRC_MEM, SRC_FLAGS
	} bus_src_e;

	typedef struct packed {
		logic z;
		logic n;
		logic c;
		logic v;
	} flags_t;

	typedef struct packed {
		bus_src_e bus_src;
		logic     ld_ar;
		logic     ld_dr;
		logic     ld_pr;
		logic     ld_ir;
		logic     gr_lo;
		logic     gr_hi;
		logic     pc_inc;
		logic     addr_from_ar;
		reg_sel_e alu_a;
		reg_sel_e alu_b;
		logic     alu_sub;
		logic     flag_we;
	} ctrl_t;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  rd;
		logic  wr;
	} mem_req_t;

endpackage

// File: datapath/cpu_regfile.sv
`timescale 1ns/100ps

`include "cpu_defines.svh"

module cpu_regfile (
	input  logic           clk,
	input  logic           rst,
	input  cpu_pkg::data_t bus,
	input  logic           ld_ar,
	input  logic           ld_dr,
	input  logic           ld_pr,
	input  logic           pc_inc,
	input  logic           gr_lo,
	input  logic           gr_hi,
	output cpu_pkg::data_t ar,
	output cpu_pkg::data_t dr,
	output cpu_pkg::data_t gr,
	output cpu_pkg::data_t pr
);

	import cpu_pkg::*;

	nibble_t bus_nib;

	assign bus_nib = bus[`CPU_NIB_W-1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ar <= '0;
			dr <= '0;
		end
		else
		begin
			if (ld_ar)
				ar <= bus;
			if (ld_dr)
				dr <= bus;
		end
	end

	// GR takes a nibble from bus bits 3:0, or the whole word when both are set
	always_ff @(posedge clk)
	begin
		if (rst)
			gr <= '0;
		else if (gr_lo && gr_hi)
			gr <= bus;
		else if (gr_lo)
			gr[`CPU_NIB_W-1:0] <= bus_nib;
		else if (gr_hi)
			gr[`CPU_DATA_W-1:`CPU_NIB_W] <= bus_nib;
	end

	// Jump load wins, though both never come together
	always_ff @(posedge clk)
	begin
		if (rst)
			pr <= '0;
		else if (ld_pr)
			pr <= bus;
		else if (pc_inc)
			pr <= pr + 1'b1;
	end

	a_pr_one_source: assert property (@(posedge clk) disable iff (rst) !(ld_pr && pc_inc));

endmodule

// File: datapath/cpu_alu.sv
`timescale 1ns/100ps

`include "cpu_defines.svh"

module cpu_alu (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::data_t    ar,
	input  cpu_pkg::data_t    dr,
	input  cpu_pkg::data_t    gr,
	input  cpu_pkg::data_t    pr,
	input  cpu_pkg::reg_sel_e alu_a,
	input  cpu_pkg::reg_sel_e alu_b,
	input  logic              alu_sub,
	input  logic              flag_we,
	output cpu_pkg::data_t    result,
	output cpu_pkg::flags_t   flags
);

	import cpu_pkg::*;

	data_t                op_a;
	data_t                op_b;
	logic [`CPU_DATA_W:0] sum;

	function automatic data_t pick(input reg_sel_e r, input data_t a, input data_t d,
		input data_t g, input data_t p);
		case (r)
			AR:      pick = a;
			DR:      pick = d;
			GR:      pick = g;
			default: pick = p;
		endcase
	endfunction

	assign op_a = pick(alu_a, ar, dr, gr, pr);

	// Subtract as a plus inverted b plus one, carry out means no borrow
	assign op_b   = alu_sub ? ~pick(alu_b, ar, dr, gr, pr) : pick(alu_b, ar, dr, gr, pr);
	assign sum    = {1'b0, op_a} + {1'b0, op_b} + {{`CPU_DATA_W{1'b0}}, alu_sub};
	assign result = sum[`CPU_DATA_W-1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
			flags <= '0;
		else if (flag_we)
		begin
			flags.z <= (result == '0);
			flags.n <= result[`CPU_DATA_W-1];
			flags.c <= sum[`CPU_DATA_W];
			// Operands of equal sign giving a result of the other sign
			flags.v <= (op_a[`CPU_DATA_W-1] == op_b[`CPU_DATA_W-1]) &&
				(result[`CPU_DATA_W-1] != op_a[`CPU_DATA_W-1]);
		end
	end

endmodule

// File: datapath/cpu_datapath.sv
`timescale 1ns/100ps

`include "cpu_defines.svh"

module cpu_datapath (
	input  logic           clk,
	input  logic           rst,
	input  cpu_pkg::ctrl_t ctrl,
	input  cpu_pkg::data_t mem_rdata,
	output cpu_pkg::data_t ir,
	output cpu_pkg::addr_t mem_addr,
	output cpu_pkg::data_t mem_wdata
);

	import cpu_pkg::*;

	data_t  ar;
	data_t  dr;
	data_t  gr;
	data_t  pr;
	data_t  alu_result;
	flags_t flags;
	data_t  bus;

	cpu_regfile u_regfile (
		.clk    (clk),
		.rst    (rst),
		.bus    (bus),
		.ld_ar  (ctrl.ld_ar),
		.ld_dr  (ctrl.ld_dr),
		.ld_pr  (ctrl.ld_pr),
		.pc_inc (ctrl.pc_inc),
		.gr_lo  (ctrl.gr_lo),
		.gr_hi  (ctrl.gr_hi),
		.ar     (ar),
		.dr     (dr),
		.gr     (gr),
		.pr     (pr)
	);

	cpu_alu u_alu (
		.clk     (clk),
		.rst     (rst),
		.ar      (ar),
		.dr      (dr),
		.gr      (gr),
		.pr      (pr),
		.alu_a   (ctrl.alu_a),
		.alu_b   (ctrl.alu_b),
		.alu_sub (ctrl.alu_sub),
		.flag_we (ctrl.flag_we),
		.result  (alu_result),
		.flags   (flags)
	);

	// Cleared to a NOP so the first decode is harmless
	always_ff @(posedge clk)
	begin
		if (rst)
			ir <= '0;
		else if (ctrl.ld_ir)
			ir <= bus;
	end

	// Single internal bus, one source per cycle
	always_comb
	begin
		bus = '0;
		case (ctrl.bus_src)
			SRC_AR:     bus = ar;
			SRC_DR:     bus = dr;
			SRC_GR:     bus = gr;
			SRC_PR:     bus = pr;
			SRC_IR_NIB: bus[`CPU_NIB_W-1:0] = ir[`CPU_NIB_W-1:0];
			SRC_ALU:    bus = alu_result;
			SRC_MEM:    bus = mem_rdata;
			SRC_FLAGS:  bus[`CPU_FLAG_W-1:0] = flags;
			default:    bus = '0;
		endcase
	end

	assign mem_addr  = ctrl.addr_from_ar ? ar : pr;
	assign mem_wdata = bus;

	// IR only ever loads from memory
	a_ir_from_mem: assert property (@(posedge clk) disable iff (rst)
		ctrl.ld_ir |-> ctrl.bus_src == SRC_MEM);

endmodule

// File: control/cpu_control.sv
`timescale 1ns/100ps

`include "cpu_defines.svh"

module cpu_control (
	input  logic           clk,
	input  logic           rst,
	input  cpu_pkg::data_t ir,
	output cpu_pkg::ctrl_t ctrl,
	output logic           mem_rd,
	output logic           mem_wr
);

	import cpu_pkg::*;

	state_e   state;
	state_e   next_state;
	opcode_e  opcode;
	reg_sel_e dst;
	reg_sel_e src;

	// Bus source that puts a programmer register on the bus
	function automatic bus_src_e reg_src(input reg_sel_e r);
		case (r)
			AR:      reg_src = SRC_AR;
			DR:      reg_src = SRC_DR;
			GR:      reg_src = SRC_GR;
			default: reg_src = SRC_PR;
		endcase
	endfunction

	// Load enable for a destination register
	// A PR load is a jump
	function automatic ctrl_t load_dst(input ctrl_t c, input reg_sel_e r);
		ctrl_t res;
		res = c;
		case (r)
			AR: res.ld_ar = 1'b1;
			DR: res.ld_dr = 1'b1;
			GR:
			begin
				res.gr_lo = 1'b1;
				res.gr_hi = 1'b1;
			end
			default: res.ld_pr = 1'b1;
		endcase
		return res;
	endfunction

	assign opcode = opcode_e'(ir[`CPU_DATA_W-1 -: `CPU_OP_W]);
	assign dst    = reg_sel_e'(ir[3:2]);
	assign src    = reg_sel_e'(ir[1:0]);

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_RST;
		else
			state <= next_state;
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction cycle and decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		ctrl       = '0;
		mem_rd     = 1'b0;
		mem_wr     = 1'b0;
		next_state = ST_RST;
		case (state)
			ST_RST:
				next_state = ST_FETCH;
			ST_FETCH:
			begin
				// PR addresses memory and IR takes the byte
				mem_rd       = 1'b1;
				ctrl.bus_src = SRC_MEM;
				ctrl.ld_ir   = 1'b1;
				ctrl.pc_inc  = 1'b1;
				next_state   = ST_DECODE;
			end
			ST_DECODE:
				next_state = ST_EXEC;
			ST_EXEC:
			begin
				next_state = ST_FETCH;
				case (opcode)
					JMP:
					begin
						ctrl.bus_src = SRC_AR;
						ctrl.ld_pr   = 1'b1;
					end
					RDM:
					begin
						mem_rd            = 1'b1;
						ctrl.addr_from_ar = 1'b1;
						ctrl.bus_src      = SRC_MEM;
						ctrl              = load_dst(ctrl, dst);
					end
					WRM:
					begin
						mem_wr            = 1'b1;
						ctrl.addr_from_ar = 1'b1;
						ctrl.bus_src      = reg_src(dst);
					end
					CPR:
						// Equal fields decode as a no-op
						if (dst != src)
						begin
							ctrl.bus_src = reg_src(src);
							ctrl         = load_dst(ctrl, dst);
						end
					ADD, SUB:
					begin
						ctrl.alu_a   = dst;
						ctrl.alu_b   = src;
						ctrl.alu_sub = (opcode == SUB);
						ctrl.flag_we = 1'b1;
						ctrl.bus_src = SRC_ALU;
						ctrl         = load_dst(ctrl, dst);
					end
					LLS:
					begin
						ctrl.bus_src = SRC_IR_NIB;
						ctrl.gr_lo   = 1'b1;
					end
					LMS:
					begin
						ctrl.bus_src = SRC_IR_NIB;
						ctrl.gr_hi   = 1'b1;
					end
					CFR:
					begin
						ctrl.bus_src = SRC_FLAGS;
						ctrl.gr_lo   = 1'b1;
					end
					default:
						;
				endcase
			end
			default:
				next_state = ST_RST;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_strobes_exclusive: assert property (@(posedge clk) !(mem_rd && mem_wr));

	// Program counter advances only while fetching
	a_pc_inc_fetch: assert property (@(posedge clk) disable iff (rst)
		ctrl.pc_inc |-> state == ST_FETCH);

endmodule

// File: design/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::data_t    mem_rdata,
	output cpu_pkg::mem_req_t mem
);

	import cpu_pkg::*;

	ctrl_t ctrl;
	data_t ir;
	addr_t mem_addr;
	data_t mem_wdata;
	logic  mem_rd;
	logic  mem_wr;

	cpu_control u_control (
		.clk    (clk),
		.rst    (rst),
		.ir     (ir),
		.ctrl   (ctrl),
		.mem_rd (mem_rd),
		.mem_wr (mem_wr)
	);

	cpu_datapath u_datapath (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.mem_rdata (mem_rdata),
		.ir        (ir),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	// Strobes come from the controller, address and data from the datapath
	assign mem.addr  = mem_addr;
	assign mem.wdata = mem_wdata;
	assign mem.rd    = mem_rd;
	assign mem.wr    = mem_wr;

endmodule

// File: bench/cpu_tb_program.svh
// Program table, one row per executed instruction in execution order
// Row layout {fetch addr, instruction, write expected, write addr, write data}

localparam int N_ROWS = 67;

localparam logic [35:0] PROGRAM [N_ROWS] = '{
	// Immediate loads and a first write to BC
	36'h00_00_0_00_00, 36'h01_7C_0_00_00, 36'h02_8B_0_00_00, 36'h03_42_0_00_00,
	36'h04_75_0_00_00, 36'h05_83_0_00_00, 36'h06_38_1_BC_35, 36'h07_46_0_00_00,
	// ADD, SUB and the flags after each
	36'h08_74_0_00_00, 36'h09_81_0_00_00, 36'h0A_59_0_00_00, 36'h0B_38_1_BC_49,
	36'h0C_90_0_00_00, 36'h0D_38_1_BC_40, 36'h0E_66_0_00_00, 36'h0F_34_1_BC_F5,
	36'h10_90_0_00_00, 36'h11_38_1_BC_44, 36'h12_6A_0_00_00, 36'h13_90_0_00_00,
	36'h14_38_1_BC_0A, 36'h15_7F_0_00_00, 36'h16_87_0_00_00, 36'h17_46_0_00_00,
	36'h18_59_0_00_00, 36'h19_38_1_BC_FE, 36'h1A_90_0_00_00, 36'h1B_38_1_BC_F5,
	36'h1C_59_0_00_00, 36'h1D_90_0_00_00, 36'h1E_38_1_BC_72,
	// Reads from the data area, written back elsewhere
	36'h1F_70_0_00_00, 36'h20_8E_0_00_00, 36'h21_42_0_00_00, 36'h22_24_0_00_00,
	36'h23_8D_0_00_00, 36'h24_42_0_00_00, 36'h25_34_1_D0_9C, 36'h26_71_0_00_00,
	36'h27_8E_0_00_00, 36'h28_42_0_00_00, 36'h29_28_0_00_00, 36'h2A_50_0_00_00,
	36'h2B_38_1_C2_3B,
	// Undefined opcodes, equal-field CPR and NOP
	36'h2C_A5_0_00_00, 36'h2D_F0_0_00_00, 36'h2E_4A_0_00_00, 36'h2F_00_0_00_00,
	36'h30_38_1_C2_3B, 36'h31_34_1_C2_9C,
	// JMP, then CPR, RDM and ADD into PR
	36'h32_70_0_00_00, 36'h33_84_0_00_00, 36'h34_42_0_00_00, 36'h35_10_0_00_00,
	36'h40_75_0_00_00, 36'h41_85_0_00_00, 36'h42_4E_0_00_00,
	36'h55_72_0_00_00, 36'h56_8E_0_00_00, 36'h57_42_0_00_00, 36'h58_2C_0_00_00,
	36'h60_70_0_00_00, 36'h61_80_0_00_00, 36'h62_7F_0_00_00, 36'h63_5E_0_00_00,
	36'h73_34_1_E2_9C, 36'h74_38_1_E2_0F
};

// Bytes placed in the data area before the run
localparam logic [7:0] DATA_BASE = 8'hE0;
localparam logic [7:0] DATA_BYTES [3] = '{8'h9C, 8'h3B, 8'h60};

// File: bench/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

	import cpu_pkg::*;

	`include "cpu_tb_program.svh"

	localparam int CYCLE_LIMIT = 3 * N_ROWS + 20;

	logic     clk;
	logic     rst;
	data_t    mem_rdata;
	mem_req_t mem;
	logic [7:0] mem_array [256];
	int       cycles;

	cpu_top DUT (
		.clk       (clk),
		.rst       (rst),
		.mem_rdata (mem_rdata),
		.mem       (mem)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "check failed");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory model with combinational read
	//////////////////////////////////////////////////////////////////////

	always_comb
		mem_rdata = mem_array[mem.addr];

	always @(posedge clk)
	begin
		if (mem.wr)
			mem_array[mem.addr] <= mem.wdata;
	end

	// Cycle limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout, program did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk)
	begin
		assert (!(mem.rd && mem.wr))
		else
			report_failure("rd and wr high together");
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [35:0] row;
		cycles = 0;
		rst    = 1'b1;
		for (int i = 0; i < 256; i++)
			mem_array[i] = i[7:0] ^ 8'h5A;
		for (int i = 0; i < N_ROWS; i++)
			mem_array[PROGRAM[i][35:28]] = PROGRAM[i][27:20];
		for (int i = 0; i < 3; i++)
			mem_array[DATA_BASE + i[7:0]] = DATA_BYTES[i];

		// Strobes stay low in reset and the cycle after
		@(posedge clk);
		@(negedge clk);
		assert (!mem.rd && !mem.wr)
		else
			report_failure("strobe high during reset");
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!mem.rd && !mem.wr)
		else
			report_failure("strobe high in the cycle after reset");

		for (int i = 0; i < N_ROWS; i++)
		begin
			row = PROGRAM[i];
			@(negedge clk);
			assert (mem.rd && mem.addr == row[35:28])
			else
				report_failure($sformatf("row %0d fetch expected at %02h, rd %b addr %02h",
					i, row[35:28], mem.rd, mem.addr));
			@(negedge clk);
			assert (!mem.rd && !mem.wr)
			else
				report_failure($sformatf("row %0d strobe high in decode", i));
			@(negedge clk);
			if (row[16])
			begin
				assert (mem.wr && mem.addr == row[15:8] && mem.wdata == row[7:0])
				else
					report_failure($sformatf("row %0d expected %02h to %02h, got %b %02h to %02h",
						i, row[7:0], row[15:8], mem.wr, mem.wdata, mem.addr));
			end
			else
			begin
				assert (!mem.wr)
				else
					report_failure($sformatf("row %0d unexpected write to %02h", i, mem.addr));
			end
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: build.f
+incdir+common
+incdir+bench
common/cpu_pkg.sv
datapath/cpu_regfile.sv
datapath/cpu_alu.sv
datapath/cpu_datapath.sv
control/cpu_control.sv
design/cpu_top.sv
bench/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
